/* src/dft_corr_pkg.sv */
package dft_corr_pkg;

    // datapath widths
    localparam int DIN_WIDTH = 16;      // real input samples
    localparam int TWIDD_WIDTH = 16;    // Q14 twiddle components
    localparam int MAC_WIDTH = 40;      // block sum, wraps
    localparam int DFT_WIDTH = 18;      // bin value after block scaling
    localparam int CORR_WIDTH = 32;     // accumulator input after product scaling
    localparam int OUT_WIDTH = 48;      // integrated result, wraps

    // input side
    typedef logic signed [DIN_WIDTH-1:0] sample_t;
    typedef logic signed [TWIDD_WIDTH-1:0] twidd_t;

    // one component of a bin value
    typedef logic signed [DFT_WIDTH-1:0] bin_t;

    // cross terms are signed, powers are not
    typedef logic signed [CORR_WIDTH-1:0] corr_s_t;
    typedef logic [CORR_WIDTH-1:0] corr_u_t;

    typedef logic signed [OUT_WIDTH-1:0] out_s_t;
    typedef logic [OUT_WIDTH-1:0] out_u_t;

endpackage

/* src/corr_control.sv */
module corr_control #(
    parameter int DFT_LEN_MAX = 64
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           din_valid,
    input  logic [31:0]                    dft_len_m1,
    input  logic [31:0]                    acc_len,
    input  logic                           corr_valid,
    output logic [$clog2(DFT_LEN_MAX)-1:0] rd_addr,
    output logic                           samp_valid,
    output logic                           samp_first,
    output logic                           samp_last,
    output logic                           acc_last
);

    localparam int ADDR_WIDTH = $clog2(DFT_LEN_MAX);

    logic [ADDR_WIDTH-1:0] samp_cnt;   // position inside the current block
    logic [31:0]           spec_cnt;   // spectrum number inside the integration
    logic                  samp_wrap;
    logic                  spec_wrap;

    assign samp_wrap = (32'(samp_cnt) == dft_len_m1);
    assign spec_wrap = (spec_cnt == acc_len);

    // sample counter, one step per incoming sample pair
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            samp_cnt <= '0;
        end else if (din_valid) begin
            if (samp_wrap) begin
                samp_cnt <= '0;
            end else begin
                samp_cnt <= samp_cnt + 1'b1;
            end
        end
    end

    // spectrum counter, steps once per finished set of products
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            spec_cnt <= '0;
        end else if (corr_valid) begin
            if (spec_wrap) begin
                spec_cnt <= '0;
            end else begin
                spec_cnt <= spec_cnt + 1'b1;
            end
        end
    end

    // sample k of a block reads twiddle k
    assign rd_addr    = samp_cnt;
    assign samp_valid = din_valid;
    assign samp_first = din_valid && (samp_cnt == '0);
    assign samp_last  = din_valid && samp_wrap;

    // level, the accumulators qualify it with their own valid
    assign acc_last = spec_wrap;

    // a longer block would run past the twiddle memory
    len_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        dft_len_m1 < DFT_LEN_MAX
    );

endmodule

/* src/twiddle_ram.sv */
module twiddle_ram #(
    parameter int DFT_LEN_MAX = 64
) (
    input  logic                           clk,
    input  logic                           we,
    input  logic [$clog2(DFT_LEN_MAX)-1:0] wr_addr,
    input  dft_corr_pkg::twidd_t           wr_re,
    input  dft_corr_pkg::twidd_t           wr_im,
    input  logic [$clog2(DFT_LEN_MAX)-1:0] rd_addr,
    output dft_corr_pkg::twidd_t           rd_re,
    output dft_corr_pkg::twidd_t           rd_im
);

    // real and imaginary parts kept side by side
    dft_corr_pkg::twidd_t mem_re [DFT_LEN_MAX];
    dft_corr_pkg::twidd_t mem_im [DFT_LEN_MAX];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem_re[wr_addr] <= wr_re;
            mem_im[wr_addr] <= wr_im;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_re <= mem_re[rd_addr];
        rd_im <= mem_im[rd_addr];
    end

endmodule

/* src/dft_bin_mac.sv */
module dft_bin_mac #(
    parameter int DFT_SHIFT = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dft_corr_pkg::sample_t din,
    input  logic                  samp_valid,
    input  logic                  samp_first,
    input  logic                  samp_last,
    input  dft_corr_pkg::twidd_t  tw_re,
    input  dft_corr_pkg::twidd_t  tw_im,
    output dft_corr_pkg::bin_t    bin_re,
    output dft_corr_pkg::bin_t    bin_im,
    output logic                  bin_valid
);

    localparam int PROD_WIDTH = dft_corr_pkg::DIN_WIDTH + dft_corr_pkg::TWIDD_WIDTH;
    localparam int MAC_WIDTH = dft_corr_pkg::MAC_WIDTH;

    dft_corr_pkg::sample_t         din_r;     // lines up with the twiddle read
    logic                          valid_d1;
    logic                          first_d1;
    logic                          last_d1;
    logic signed [PROD_WIDTH-1:0]  prod_re;
    logic signed [PROD_WIDTH-1:0]  prod_im;
    logic                          valid_d2;
    logic                          first_d2;
    logic                          last_d2;
    logic signed [MAC_WIDTH-1:0]   sum_re;
    logic signed [MAC_WIDTH-1:0]   sum_im;
    logic signed [MAC_WIDTH-1:0]   next_re;
    logic signed [MAC_WIDTH-1:0]   next_im;
    logic signed [MAC_WIDTH-1:0]   shift_re;
    logic signed [MAC_WIDTH-1:0]   shift_im;

    // flags follow the data through both stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d1  <= 1'b0;
            first_d1  <= 1'b0;
            last_d1   <= 1'b0;
            valid_d2  <= 1'b0;
            first_d2  <= 1'b0;
            last_d2   <= 1'b0;
            bin_valid <= 1'b0;
        end else begin
            valid_d1  <= samp_valid;
            first_d1  <= samp_first;
            last_d1   <= samp_last;
            valid_d2  <= valid_d1;
            first_d2  <= first_d1;
            last_d2   <= last_d1;
            bin_valid <= valid_d2 && last_d2;
        end
    end

    always_ff @(posedge clk) begin
        if (samp_valid) begin
            din_r <= din;
        end
        prod_re <= din_r * tw_re;   // real sample, so two products only
        prod_im <= din_r * tw_im;
    end

    // first sample of a block reloads instead of adding
    always_comb begin
        next_re  = first_d2 ? MAC_WIDTH'(prod_re) : sum_re + prod_re;
        next_im  = first_d2 ? MAC_WIDTH'(prod_im) : sum_im + prod_im;
        shift_re = next_re >>> DFT_SHIFT;
        shift_im = next_im >>> DFT_SHIFT;
    end

    always_ff @(posedge clk) begin
        if (valid_d2) begin
            sum_re <= next_re;
            sum_im <= next_im;
        end
        if (valid_d2 && last_d2) begin
            bin_re <= shift_re[dft_corr_pkg::DFT_WIDTH-1:0];   // truncate
            bin_im <= shift_im[dft_corr_pkg::DFT_WIDTH-1:0];
        end
    end

    // block markers from control only come with a sample
    flags_need_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (samp_first || samp_last) |-> samp_valid
    );

endmodule

/* src/cross_power_mults.sv */
module cross_power_mults #(
    parameter int CORR_SHIFT = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dft_corr_pkg::bin_t    bin0_re,
    input  dft_corr_pkg::bin_t    bin0_im,
    input  dft_corr_pkg::bin_t    bin1_re,
    input  dft_corr_pkg::bin_t    bin1_im,
    input  logic                  bin_valid,
    output dft_corr_pkg::corr_u_t aa,
    output dft_corr_pkg::corr_u_t bb,
    output dft_corr_pkg::corr_s_t ab_re,
    output dft_corr_pkg::corr_s_t ab_im,
    output logic                  corr_valid
);

    localparam int PROD_WIDTH = 2 * dft_corr_pkg::DFT_WIDTH;
    localparam int SUM_WIDTH = PROD_WIDTH + 1;   // 37 bits, exact

    logic signed [PROD_WIDTH-1:0] p_re0_re0;
    logic signed [PROD_WIDTH-1:0] p_im0_im0;
    logic signed [PROD_WIDTH-1:0] p_re1_re1;
    logic signed [PROD_WIDTH-1:0] p_im1_im1;
    logic signed [PROD_WIDTH-1:0] p_re0_re1;
    logic signed [PROD_WIDTH-1:0] p_im0_im1;
    logic signed [PROD_WIDTH-1:0] p_im0_re1;
    logic signed [PROD_WIDTH-1:0] p_re0_im1;
    logic                         prod_valid;
    logic signed [SUM_WIDTH-1:0]  aa_sum;
    logic signed [SUM_WIDTH-1:0]  bb_sum;
    logic signed [SUM_WIDTH-1:0]  re_sum;
    logic signed [SUM_WIDTH-1:0]  im_sum;

    // arithmetic shift, then keep the low bits
    function automatic logic [dft_corr_pkg::CORR_WIDTH-1:0] scale(
        input logic signed [SUM_WIDTH-1:0] x
    );
        logic signed [SUM_WIDTH-1:0] s;
        s = x >>> CORR_SHIFT;
        return s[dft_corr_pkg::CORR_WIDTH-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            corr_valid <= 1'b0;
        end else begin
            prod_valid <= bin_valid;
            corr_valid <= prod_valid;
        end
    end

    // stage one, all eight component products
    always_ff @(posedge clk) begin
        p_re0_re0 <= bin0_re * bin0_re;
        p_im0_im0 <= bin0_im * bin0_im;
        p_re1_re1 <= bin1_re * bin1_re;
        p_im1_im1 <= bin1_im * bin1_im;
        p_re0_re1 <= bin0_re * bin1_re;
        p_im0_im1 <= bin0_im * bin1_im;
        p_im0_re1 <= bin0_im * bin1_re;
        p_re0_im1 <= bin0_re * bin1_im;
    end

    // a times conj(b)
    assign aa_sum = p_re0_re0 + p_im0_im0;
    assign bb_sum = p_re1_re1 + p_im1_im1;
    assign re_sum = p_re0_re1 + p_im0_im1;
    assign im_sum = p_im0_re1 - p_re0_im1;

    // stage two, scaled to accumulator width
    always_ff @(posedge clk) begin
        aa    <= scale(aa_sum);   // never negative, shift is the same either way
        bb    <= scale(bb_sum);
        ab_re <= scale(re_sum);
        ab_im <= scale(im_sum);
    end

endmodule

/* src/spectrum_accumulator.sv */
module spectrum_accumulator #(
    parameter type acc_in_t = dft_corr_pkg::corr_s_t,
    parameter type acc_out_t = dft_corr_pkg::out_s_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  acc_in_t  din,
    input  logic     din_valid,
    input  logic     acc_last,
    output acc_out_t dout,
    output logic     dout_valid
);

    acc_out_t sum;        // running sum of the current integration
    acc_out_t sum_next;

    // extension follows the signedness of the input type
    assign sum_next = sum + acc_out_t'(din);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum        <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid && acc_last;
            if (din_valid) begin
                // restart right after the last spectrum
                sum <= acc_last ? acc_out_t'(0) : sum_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid && acc_last) begin
            dout <= sum_next;   // held until the next integration ends
        end
    end

    // products reaching the sum are never unknown
    din_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        din_valid |-> !$isunknown(din)
    );

endmodule

/* src/dft_correlator_top.sv */
module dft_correlator_top #(
    parameter int DFT_LEN_MAX = 64,
    parameter int DFT_SHIFT = 12,
    parameter int CORR_SHIFT = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  dft_corr_pkg::sample_t          din0,
    input  dft_corr_pkg::sample_t          din1,
    input  logic                           din_valid,
    input  logic [31:0]                    dft_len_m1,
    input  logic [31:0]                    acc_len,
    input  logic                           twidd_we,
    input  logic [$clog2(DFT_LEN_MAX)-1:0] twidd_addr,
    input  dft_corr_pkg::twidd_t           twidd_re,
    input  dft_corr_pkg::twidd_t           twidd_im,
    output dft_corr_pkg::out_u_t           aa,
    output dft_corr_pkg::out_u_t           bb,
    output dft_corr_pkg::out_s_t           ab_re,
    output dft_corr_pkg::out_s_t           ab_im,
    output logic                           dout_valid
);

    localparam int ADDR_WIDTH = $clog2(DFT_LEN_MAX);

    logic [ADDR_WIDTH-1:0]  rd_addr;
    logic                   samp_valid;
    logic                   samp_first;
    logic                   samp_last;
    logic                   acc_last;
    dft_corr_pkg::twidd_t   tw_re;
    dft_corr_pkg::twidd_t   tw_im;
    dft_corr_pkg::bin_t     bin0_re;
    dft_corr_pkg::bin_t     bin0_im;
    dft_corr_pkg::bin_t     bin1_re;
    dft_corr_pkg::bin_t     bin1_im;
    logic                   bin0_valid;
    dft_corr_pkg::corr_u_t  corr_aa;
    dft_corr_pkg::corr_u_t  corr_bb;
    dft_corr_pkg::corr_s_t  corr_re;
    dft_corr_pkg::corr_s_t  corr_im;
    logic                   corr_valid;

    corr_control #(
        .DFT_LEN_MAX(DFT_LEN_MAX)
    ) u_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .din_valid(din_valid),
        .dft_len_m1(dft_len_m1),
        .acc_len(acc_len),
        .corr_valid(corr_valid),
        .rd_addr(rd_addr),
        .samp_valid(samp_valid),
        .samp_first(samp_first),
        .samp_last(samp_last),
        .acc_last(acc_last)
    );

    twiddle_ram #(
        .DFT_LEN_MAX(DFT_LEN_MAX)
    ) u_twidd (
        .clk(clk),
        .we(twidd_we),
        .wr_addr(twidd_addr),
        .wr_re(twidd_re),
        .wr_im(twidd_im),
        .rd_addr(rd_addr),
        .rd_re(tw_re),
        .rd_im(tw_im)
    );

    // both inputs share the twiddle stream and the block markers
    dft_bin_mac #(
        .DFT_SHIFT(DFT_SHIFT)
    ) u_mac0 (
        .clk(clk),
        .rst_n(rst_n),
        .din(din0),
        .samp_valid(samp_valid),
        .samp_first(samp_first),
        .samp_last(samp_last),
        .tw_re(tw_re),
        .tw_im(tw_im),
        .bin_re(bin0_re),
        .bin_im(bin0_im),
        .bin_valid(bin0_valid)
    );

    dft_bin_mac #(
        .DFT_SHIFT(DFT_SHIFT)
    ) u_mac1 (
        .clk(clk),
        .rst_n(rst_n),
        .din(din1),
        .samp_valid(samp_valid),
        .samp_first(samp_first),
        .samp_last(samp_last),
        .tw_re(tw_re),
        .tw_im(tw_im),
        .bin_re(bin1_re),
        .bin_im(bin1_im),
        .bin_valid()
    );

    cross_power_mults #(
        .CORR_SHIFT(CORR_SHIFT)
    ) u_mults (
        .clk(clk),
        .rst_n(rst_n),
        .bin0_re(bin0_re),
        .bin0_im(bin0_im),
        .bin1_re(bin1_re),
        .bin1_im(bin1_im),
        .bin_valid(bin0_valid),
        .aa(corr_aa),
        .bb(corr_bb),
        .ab_re(corr_re),
        .ab_im(corr_im),
        .corr_valid(corr_valid)
    );

    // powers integrate unsigned
    spectrum_accumulator #(
        .acc_in_t(dft_corr_pkg::corr_u_t),
        .acc_out_t(dft_corr_pkg::out_u_t)
    ) u_acc_aa (
        .clk(clk),
        .rst_n(rst_n),
        .din(corr_aa),
        .din_valid(corr_valid),
        .acc_last(acc_last),
        .dout(aa),
        .dout_valid()
    );

    spectrum_accumulator #(
        .acc_in_t(dft_corr_pkg::corr_u_t),
        .acc_out_t(dft_corr_pkg::out_u_t)
    ) u_acc_bb (
        .clk(clk),
        .rst_n(rst_n),
        .din(corr_bb),
        .din_valid(corr_valid),
        .acc_last(acc_last),
        .dout(bb),
        .dout_valid()
    );

    spectrum_accumulator #(
        .acc_in_t(dft_corr_pkg::corr_s_t),
        .acc_out_t(dft_corr_pkg::out_s_t)
    ) u_acc_re (
        .clk(clk),
        .rst_n(rst_n),
        .din(corr_re),
        .din_valid(corr_valid),
        .acc_last(acc_last),
        .dout(ab_re),
        .dout_valid(dout_valid)   // stands for all four
    );

    spectrum_accumulator #(
        .acc_in_t(dft_corr_pkg::corr_s_t),
        .acc_out_t(dft_corr_pkg::out_s_t)
    ) u_acc_im (
        .clk(clk),
        .rst_n(rst_n),
        .din(corr_im),
        .din_valid(corr_valid),
        .acc_last(acc_last),
        .dout(ab_im),
        .dout_valid()
    );

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES = 3
) (
    input  logic rst_req,
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int   rst_cnt = RST_CYCLES;   // reset cycles still to go
    logic req_q = 1'b0;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // request caught on the rising edge
    always @(posedge clk) begin
        req_q <= rst_req;
    end

    // reset itself moves on the falling edge, like every other input
    always @(negedge clk) begin
        if (req_q) begin
            rst_cnt <= RST_CYCLES;
        end else if (rst_cnt != 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign rst_n = (rst_cnt == 0);

endmodule

/* sim/tb_dft_correlator.sv */
module tb_dft_correlator;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DFT_LEN_MAX = 64;
    localparam int DFT_SHIFT = 12;
    localparam int CORR_SHIFT = 4;
    localparam int ADDR_WIDTH = $clog2(DFT_LEN_MAX);
    localparam int OUT_WIDTH = dft_corr_pkg::OUT_WIDTH;

    // test sizes, in blocks or integrations
    localparam int IDLE_CYCLES = 20;
    localparam int STREAM_BLOCKS = 8;
    localparam int INTEG_RUNS = 3;
    localparam int GAP_RUNS = 3;
    localparam int SHORT_RUNS = 4;
    localparam int PLAN_CYCLES = IDLE_CYCLES + 2 * DFT_LEN_MAX
                               + STREAM_BLOCKS * 16
                               + INTEG_RUNS * 4 * 16
                               + GAP_RUNS * 2 * 16 * 4
                               + SHORT_RUNS * 3 * 8 * 2
                               + 5 * 20;   // resets and pipeline drain
    localparam int TIMEOUT_CYCLES = 4 * PLAN_CYCLES + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  rst_req;
    dft_corr_pkg::sample_t din0;
    dft_corr_pkg::sample_t din1;
    logic                  din_valid;
    logic [31:0]           dft_len_m1;
    logic [31:0]           acc_len;
    logic                  twidd_we;
    logic [ADDR_WIDTH-1:0] twidd_addr;
    dft_corr_pkg::twidd_t  twidd_re;
    dft_corr_pkg::twidd_t  twidd_im;
    dft_corr_pkg::out_u_t  aa;
    dft_corr_pkg::out_u_t  bb;
    dft_corr_pkg::out_s_t  ab_re;
    dft_corr_pkg::out_s_t  ab_im;
    logic                  dout_valid;

    logic [31:0]          lcg_state = 32'hc1cabd84;
    int                   tw_re_tab [DFT_LEN_MAX];   // copy of what went into the twiddle ram
    int                   tw_im_tab [DFT_LEN_MAX];
    int                   blk0 [DFT_LEN_MAX];        // samples of the current block
    int                   blk1 [DFT_LEN_MAX];
    logic [OUT_WIDTH-1:0] exp_aa_q [$];
    logic [OUT_WIDTH-1:0] exp_bb_q [$];
    logic [OUT_WIDTH-1:0] exp_re_q [$];
    logic [OUT_WIDTH-1:0] exp_im_q [$];
    int                   due_q [$];                 // cycle each dout_valid is due
    int                   cyc = 0;
    int                   n_checks = 0;
    int                   n_errors = 0;
    int                   n_tests = 0;
    int                   n_failed = 0;

    tb_clock_gen #(
        .HALF_PERIOD(10),
        .RST_CYCLES(3)
    ) u_clk_gen (
        .rst_req(rst_req),
        .clk(clk),
        .rst_n(rst_n)
    );

    dft_correlator_top #(
        .DFT_LEN_MAX(DFT_LEN_MAX),
        .DFT_SHIFT(DFT_SHIFT),
        .CORR_SHIFT(CORR_SHIFT)
    ) uut (
        .clk(clk),
        .rst_n(rst_n),
        .din0(din0),
        .din1(din1),
        .din_valid(din_valid),
        .dft_len_m1(dft_len_m1),
        .acc_len(acc_len),
        .twidd_we(twidd_we),
        .twidd_addr(twidd_addr),
        .twidd_re(twidd_re),
        .twidd_im(twidd_im),
        .aa(aa),
        .bb(bb),
        .ab_re(ab_re),
        .ab_im(ab_im),
        .dout_valid(dout_valid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // signed value from the upper bits, scaled down by amp_shift
    function automatic int rand_sample(input int amp_shift);
        logic [31:0] r;
        r = lcg_next();
        return int'($signed(r[31:16])) >>> amp_shift;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:8] % n);
    endfunction

    function automatic longint sext(input longint v, input int w);
        longint t;
        t = v << (64 - w);
        return t >>> (64 - w);
    endfunction

    function automatic longint zext(input longint v, input int w);
        return v & ((longint'(1) << w) - 1);
    endfunction

    // one block through both DFTs and the cross products
    function automatic void model_block(input int n, output longint c_aa, output longint c_bb,
                                        output longint c_re, output longint c_im);
        longint s0r;
        longint s0i;
        longint s1r;
        longint s1i;
        longint b0r;
        longint b0i;
        longint b1r;
        longint b1i;
        int     k;
        s0r = 0;
        s0i = 0;
        s1r = 0;
        s1i = 0;
        for (k = 0; k < n; k++) begin
            s0r = sext(s0r + longint'(blk0[k]) * tw_re_tab[k], dft_corr_pkg::MAC_WIDTH);
            s0i = sext(s0i + longint'(blk0[k]) * tw_im_tab[k], dft_corr_pkg::MAC_WIDTH);
            s1r = sext(s1r + longint'(blk1[k]) * tw_re_tab[k], dft_corr_pkg::MAC_WIDTH);
            s1i = sext(s1i + longint'(blk1[k]) * tw_im_tab[k], dft_corr_pkg::MAC_WIDTH);
        end
        b0r = sext(s0r >>> DFT_SHIFT, dft_corr_pkg::DFT_WIDTH);
        b0i = sext(s0i >>> DFT_SHIFT, dft_corr_pkg::DFT_WIDTH);
        b1r = sext(s1r >>> DFT_SHIFT, dft_corr_pkg::DFT_WIDTH);
        b1i = sext(s1i >>> DFT_SHIFT, dft_corr_pkg::DFT_WIDTH);
        // powers unsigned, a times conj(b) signed
        c_aa = zext((b0r * b0r + b0i * b0i) >>> CORR_SHIFT, dft_corr_pkg::CORR_WIDTH);
        c_bb = zext((b1r * b1r + b1i * b1i) >>> CORR_SHIFT, dft_corr_pkg::CORR_WIDTH);
        c_re = sext((b0r * b1r + b0i * b1i) >>> CORR_SHIFT, dft_corr_pkg::CORR_WIDTH);
        c_im = sext((b0i * b1r - b0r * b1i) >>> CORR_SHIFT, dft_corr_pkg::CORR_WIDTH);
    endfunction

    task automatic load_twiddles(input int amp_shift);
        int a;
        for (a = 0; a < DFT_LEN_MAX; a++) begin
            @(negedge clk);
            tw_re_tab[a] = rand_sample(amp_shift);
            tw_im_tab[a] = rand_sample(amp_shift);
            twidd_we = 1'b1;
            twidd_addr = ADDR_WIDTH'(a);
            twidd_re = dft_corr_pkg::twidd_t'(tw_re_tab[a]);
            twidd_im = dft_corr_pkg::twidd_t'(tw_im_tab[a]);
        end
        @(negedge clk);
        twidd_we = 1'b0;
    endtask

    // new lengths only count after a reset
    task automatic reset_dut(input int len_m1, input int acc);
        @(negedge clk);
        dft_len_m1 = len_m1;
        acc_len = acc;
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        @(posedge clk);
        while (rst_n !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic run_stream(input int n_integ, input int len_m1, input int acc,
                              input int max_gap, input int amp_shift);
        longint c_aa;
        longint c_bb;
        longint c_re;
        longint c_im;
        longint s_aa;
        longint s_bb;
        longint s_re;
        longint s_im;
        int     i;
        int     j;
        int     k;
        int     gap;
        int     due;
        for (i = 0; i < n_integ; i++) begin
            s_aa = 0;
            s_bb = 0;
            s_re = 0;
            s_im = 0;
            for (j = 0; j <= acc; j++) begin
                for (k = 0; k <= len_m1; k++) begin
                    gap = rand_below(max_gap + 1);
                    repeat (gap) begin
                        @(negedge clk);
                        din_valid = 1'b0;
                    end
                    blk0[k] = rand_sample(amp_shift);
                    blk1[k] = rand_sample(amp_shift);
                    @(negedge clk);
                    din_valid = 1'b1;
                    din0 = dft_corr_pkg::sample_t'(blk0[k]);
                    din1 = dft_corr_pkg::sample_t'(blk1[k]);
                end
                due = cyc + 6;   // counted from the last sample of the block
                model_block(len_m1 + 1, c_aa, c_bb, c_re, c_im);
                s_aa = zext(s_aa + c_aa, OUT_WIDTH);
                s_bb = zext(s_bb + c_bb, OUT_WIDTH);
                s_re = sext(s_re + c_re, OUT_WIDTH);
                s_im = sext(s_im + c_im, OUT_WIDTH);
            end
            exp_aa_q.push_back(s_aa[OUT_WIDTH-1:0]);
            exp_bb_q.push_back(s_bb[OUT_WIDTH-1:0]);
            exp_re_q.push_back(s_re[OUT_WIDTH-1:0]);
            exp_im_q.push_back(s_im[OUT_WIDTH-1:0]);
            due_q.push_back(due);
        end
        @(negedge clk);
        din_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (due_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic check_result();
        logic [OUT_WIDTH-1:0] e_aa;
        logic [OUT_WIDTH-1:0] e_bb;
        logic [OUT_WIDTH-1:0] e_re;
        logic [OUT_WIDTH-1:0] e_im;
        int                   due;
        e_aa = exp_aa_q.pop_front();
        e_bb = exp_bb_q.pop_front();
        e_re = exp_re_q.pop_front();
        e_im = exp_im_q.pop_front();
        due = due_q.pop_front();
        n_checks += 5;
        if (aa !== e_aa) begin
            $display("Mismatch aa: got %h expected %h", aa, e_aa);
            n_errors++;
        end
        if (bb !== e_bb) begin
            $display("Mismatch bb: got %h expected %h", bb, e_bb);
            n_errors++;
        end
        if (ab_re !== e_re) begin
            $display("Mismatch ab_re: got %h expected %h", ab_re, e_re);
            n_errors++;
        end
        if (ab_im !== e_im) begin
            $display("Mismatch ab_im: got %h expected %h", ab_im, e_im);
            n_errors++;
        end
        if (cyc != due) begin
            $display("dout_valid came at cycle %0d but was due at cycle %0d", cyc, due);
            n_errors++;
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) begin
            $display("%s: passed", name);
        end else begin
            n_failed++;
            $display("%s: failed with %0d errors", name, n_errors - errs_before);
        end
    endtask

    // outputs are compared half a cycle after they change
    always @(negedge clk) begin
        if (dout_valid === 1'b1) begin
            if (due_q.size() == 0) begin
                $display("dout_valid at cycle %0d with no result expected", cyc);
                n_errors++;
            end else begin
                check_result();
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout, the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int errs;
        rst_req = 1'b0;
        din0 = '0;
        din1 = '0;
        din_valid = 1'b0;
        dft_len_m1 = 32'd15;
        acc_len = 32'd0;
        twidd_we = 1'b0;
        twidd_addr = '0;
        twidd_re = '0;
        twidd_im = '0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
        end

        errs = n_errors;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            n_checks++;
            if (dout_valid !== 1'b0) begin
                $display("Mismatch dout_valid: got %h expected %h with no samples sent",
                         dout_valid, 1'b0);
                n_errors++;
            end
        end
        close_test("after reset", errs);

        load_twiddles(1);   // Q14 range
        errs = n_errors;
        reset_dut(15, 0);
        run_stream(STREAM_BLOCKS, 15, 0, 0, 4);
        wait_drain();
        close_test("continuous streaming", errs);

        errs = n_errors;
        reset_dut(15, 3);
        run_stream(INTEG_RUNS, 15, 3, 0, 4);
        wait_drain();
        close_test("integration over spectra", errs);

        // full-range samples make the bin truncation wrap
        errs = n_errors;
        reset_dut(15, 1);
        run_stream(GAP_RUNS, 15, 1, 3, 0);
        wait_drain();
        close_test("idle gaps", errs);

        errs = n_errors;
        reset_dut(7, 2);
        load_twiddles(0);
        run_stream(SHORT_RUNS, 7, 2, 1, 0);
        wait_drain();
        close_test("shorter block", errs);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/dft_corr_pkg.sv
src/corr_control.sv
src/twiddle_ram.sv
src/dft_bin_mac.sv
src/cross_power_mults.sv
src/spectrum_accumulator.sv
src/dft_correlator_top.sv
sim/tb_clock_gen.sv
sim/tb_dft_correlator.sv
